/* hw/app_params.svh */
`ifndef APP_PARAMS_SVH
`define APP_PARAMS_SVH

// ==============================
// Serial message format
// ==============================
`define APP_MSG_LEN             64
`define APP_RESP_LEN            64
`define APP_TYPE_LEN            8
`define APP_ARG_LEN             56
`define APP_TYPE_RESP_BIT       6   // Set in the type when a response follows

// Type codes, MSB always set so the start bit is the type MSB
`define APP_TYPE_ECHO           8'hC0
`define APP_TYPE_LED_SET        8'h81
`define APP_TYPE_STATUS         8'hC2
`define APP_TYPE_NOP            8'h80

`define APP_LED_COUNT           4

// ==============================
// SD data-in capture
// ==============================
`define APP_DAT_WIDTH           16
`define APP_BLOCK_WORDS         32  // 512-bit block
`define APP_WORD_COUNT_LEN      6   // Holds 0 to APP_BLOCK_WORDS
`define APP_ACCESS_MODE_LEN     4
`define APP_CMD6_WORD_IDX       8
`define APP_CMD6_MODE_LSB       8   // Nibble sits in bits 11:8

`endif

/* hw/app_pkg.sv */
`include "app_params.svh"

package app_pkg;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [`APP_TYPE_LEN-1:0]        msg_type_t;
    typedef logic [`APP_ARG_LEN-1:0]         msg_arg_t;
    typedef logic [`APP_RESP_LEN-1:0]        resp_word_t;
    typedef logic [`APP_DAT_WIDTH-1:0]       dat_word_t;
    typedef logic [`APP_LED_COUNT-1:0]       led_t;
    typedef logic [`APP_ACCESS_MODE_LEN-1:0] access_mode_t;
    typedef logic [`APP_WORD_COUNT_LEN-1:0]  word_count_t;

    // ==============================
    // Structs
    // ==============================
    // Type first, so it lines up with the first bits on the wire
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  msg_arg;
    } msg_t;

    // Field order matches the status response layout
    typedef struct packed {
        access_mode_t access_mode;
        logic         block_done;   // All words of the block taken
        word_count_t  word_count;
    } sd_status_t;

    // Message decoder FSM
    typedef enum logic {
        IDLE,
        SHIFT
    } dec_state_t;

endpackage

/* hw/msg_decoder.sv */
`timescale 1ns/100ps
`include "app_params.svh"

module msg_decoder (
    input  logic          sd_datInWrite_clk,
    input  logic          spi_rst_,
    input  logic          data_in,
    output logic          msg_valid,
    output app_pkg::msg_t msg
);

    localparam int CNT_W = $clog2(`APP_MSG_LEN);

    app_pkg::dec_state_t     state;
    logic [CNT_W-1:0]        bit_cnt;   // Bits still to come after the start bit
    logic [`APP_MSG_LEN-1:0] shift_q;
    logic                    shift_en;

    // ==============================
    // Control FSM
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            state     <= app_pkg::IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state)
                app_pkg::IDLE: begin
                    // First high bit is the start bit and the type MSB
                    if (data_in) begin
                        state   <= app_pkg::SHIFT;
                        bit_cnt <= CNT_W'(`APP_MSG_LEN - 1);
                    end
                end
                app_pkg::SHIFT: begin
                    if (bit_cnt == '0) begin
                        msg_valid <= 1'b1;   // Whole message in shift_q
                        state     <= app_pkg::IDLE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                default: state <= app_pkg::IDLE;
            endcase
        end
    end

    // Sample on the start bit and on each of the 63 bits after it
    assign shift_en = (state == app_pkg::IDLE) ? data_in : (bit_cnt != '0);

    // ==============================
    // Message shift register
    // ==============================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (shift_en) begin
            shift_q <= {shift_q[`APP_MSG_LEN-2:0], data_in};   // MSB first
        end
    end

    // Held stable while idle, so it doubles as the output register
    assign msg = app_pkg::msg_t'(shift_q);

    // The host keeps the line at a known level once out of reset
    a_data_in_known: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        !$isunknown(data_in)
    ) else $error("data_in has an unknown value");

endmodule

/* hw/cmd_executor.sv */
`timescale 1ns/100ps
`include "app_params.svh"

module cmd_executor (
    input  logic                sd_datInWrite_clk,
    input  logic                spi_rst_,
    input  logic                msg_valid,
    input  app_pkg::msg_t       msg,
    input  app_pkg::sd_status_t status,
    output app_pkg::led_t       led,
    output logic                resp_valid,
    output app_pkg::resp_word_t resp
);

    // Zero fill below the payload of each response
    localparam int ECHO_PAD   = `APP_RESP_LEN - `APP_ARG_LEN;
    localparam int STATUS_PAD = `APP_RESP_LEN - $bits(app_pkg::sd_status_t);

    app_pkg::resp_word_t resp_next;
    logic                resp_flag;
    logic                led_load;

    assign resp_flag = msg.msg_type[`APP_TYPE_RESP_BIT];
    assign led_load  = msg_valid && (msg.msg_type == `APP_TYPE_LED_SET);

    // ==============================
    // Response word
    // ==============================
    always_comb begin
        case (msg.msg_type)
            `APP_TYPE_ECHO: begin
                resp_next = {msg.msg_arg, {ECHO_PAD{1'b0}}};   // Arg in 63:8
            end
            `APP_TYPE_STATUS: begin
                // Mode 63:60, block done 59, word count 58:53
                resp_next = {status, {STATUS_PAD{1'b0}}};
            end
            default: begin
                resp_next = '0;   // LED set, Nop and unknown types answer zeros
            end
        endcase
    end

    // ==============================
    // LED register and response strobe
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led        <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= msg_valid && resp_flag;
            if (led_load) begin
                led <= msg.msg_arg[`APP_LED_COUNT-1:0];
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (msg_valid) begin
            resp <= resp_next;
        end
    end

    // Every decoded message carries known bits
    a_msg_known: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        msg_valid |-> !$isunknown(msg)
    ) else $error("msg has unknown bits while msg_valid is high");

endmodule

/* hw/resp_shifter.sv */
`timescale 1ns/100ps
`include "app_params.svh"

module resp_shifter (
    input  logic                sd_datInWrite_clk,
    input  logic                spi_rst_,
    input  logic                resp_valid,
    input  app_pkg::resp_word_t resp,
    output logic                data_out,
    output logic                data_oe
);

    localparam int CNT_W = $clog2(`APP_RESP_LEN);

    logic [CNT_W-1:0]    bit_cnt;   // Bits left after the current one
    app_pkg::resp_word_t shift_q;

    // ==============================
    // Output enable and bit counter
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            data_oe <= 1'b0;
            bit_cnt <= '0;
        end else if (resp_valid) begin
            data_oe <= 1'b1;                        // MSB goes out right away
            bit_cnt <= CNT_W'(`APP_RESP_LEN - 1);
        end else if (data_oe) begin
            if (bit_cnt == '0) begin
                data_oe <= 1'b0;                    // Last bit done
            end else begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_valid) begin
            shift_q <= resp;
        end else if (data_oe) begin
            shift_q <= {shift_q[`APP_RESP_LEN-2:0], 1'b0};
        end
    end

    // Line stays low while not driving
    assign data_out = data_oe && shift_q[`APP_RESP_LEN-1];

    // New response only once the previous one has gone out
    a_no_resp_overlap: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        resp_valid |-> (!data_oe || bit_cnt == '0)
    ) else $error("resp_valid while a response is still shifting");

endmodule

/* hw/cmd6_capture.sv */
`timescale 1ns/100ps
`include "app_params.svh"

module cmd6_capture (
    input  logic                sd_datInWrite_clk,
    input  logic                spi_rst_,
    input  logic                dat_in_rst,
    input  logic                dat_in_trigger,
    input  app_pkg::dat_word_t  dat_in_data,
    output app_pkg::sd_status_t status
);

    localparam app_pkg::word_count_t MODE_IDX  = app_pkg::word_count_t'(`APP_CMD6_WORD_IDX);
    localparam app_pkg::word_count_t LAST_WORD = app_pkg::word_count_t'(`APP_BLOCK_WORDS - 1);

    logic take_word;

    // Always accepted, counting stops once the block is full
    assign take_word = dat_in_trigger && !status.block_done;

    // ==============================
    // Word counter and mode capture
    // ==============================
    always_ff @(posedge sd_datInWrite_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            status <= '0;
        end else if (dat_in_rst) begin
            // Restart of the block, mode keeps its last value
            status.word_count <= '0;
            status.block_done <= 1'b0;
        end else if (take_word) begin
            if (status.word_count == MODE_IDX) begin
                status.access_mode <=
                    dat_in_data[`APP_CMD6_MODE_LSB +: `APP_ACCESS_MODE_LEN];
            end
            status.word_count <= status.word_count + 1'b1;
            if (status.word_count == LAST_WORD) begin
                status.block_done <= 1'b1;   // 32nd word
            end
        end
    end

    // The SD side must present real data with every trigger
    a_dat_known: assert property (
        @(posedge sd_datInWrite_clk) disable iff (!spi_rst_)
        dat_in_trigger |-> !$isunknown(dat_in_data)
    ) else $error("dat_in_data has unknown bits while dat_in_trigger is high");

endmodule

/* hw/app_top.sv */
`timescale 1ns/100ps

module app_top (
    input  logic               sd_datInWrite_clk,
    input  logic               spi_rst_,

    // Serial command channel
    input  logic               data_in,
    output logic               data_out,
    output logic               data_oe,

    output app_pkg::led_t      led,

    // SD data-in stream
    input  logic               dat_in_rst,
    input  logic               dat_in_trigger,
    input  app_pkg::dat_word_t dat_in_data
);

    logic                msg_valid;
    app_pkg::msg_t       msg;
    logic                resp_valid;
    app_pkg::resp_word_t resp;
    app_pkg::sd_status_t status;

    // ==============================
    // Command path
    // ==============================
    msg_decoder msg_decoder_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .data_in           (data_in),
        .msg_valid         (msg_valid),
        .msg               (msg)
    );

    cmd_executor cmd_executor_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .msg_valid         (msg_valid),
        .msg               (msg),
        .status            (status),
        .led               (led),
        .resp_valid        (resp_valid),
        .resp              (resp)
    );

    resp_shifter resp_shifter_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .resp_valid        (resp_valid),
        .resp              (resp),
        .data_out          (data_out),
        .data_oe           (data_oe)
    );

    // ==============================
    // SD data-in observer
    // ==============================
    cmd6_capture cmd6_capture_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .dat_in_rst        (dat_in_rst),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data),
        .status            (status)          // Read back by Status messages
    );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic sd_datInWrite_clk,
    output logic spi_rst_
);

    initial begin
        sd_datInWrite_clk = 1'b0;
        forever #(PERIOD_NS / 2) sd_datInWrite_clk = ~sd_datInWrite_clk;
    end

    // Low from time zero, released just after an edge
    initial begin
        spi_rst_ = 1'b0;
        repeat (RST_CYCLES) @(posedge sd_datInWrite_clk);
        #10 spi_rst_ = 1'b1;
    end

endmodule

/* verification/app_tb.sv */
`timescale 1ns/100ps
`include "app_params.svh"

module app_tb;

    // One row of the stimulus table, either a message or a data-in burst
    typedef struct packed {
        logic                  is_burst;
        app_pkg::msg_t         msg;
        logic                  resp_exp;
        app_pkg::resp_word_t   resp;
        app_pkg::led_t         led;
        app_pkg::word_count_t  count;
        logic                  rst_first;
        logic                  rand_data;
        logic                  gaps;
        app_pkg::access_mode_t mode;
    } step_t;

    logic                sd_datInWrite_clk;
    logic                spi_rst_;
    logic                data_in;
    logic                data_out;
    logic                data_oe;
    app_pkg::led_t       led;
    logic                dat_in_rst;
    logic                dat_in_trigger;
    app_pkg::dat_word_t  dat_in_data;

    step_t               steps[$];
    int unsigned         seed_val;
    int                  check_count;
    int                  fail_count;
    int                  missing_count;
    int                  cycle_count;
    int                  cycle_limit;
    logic                resp_window;   // Host expects data_oe high
    app_pkg::led_t       prev_led;
    int                  blk_idx;       // Words taken in the current block
    logic                blk_full;

    tb_clock tb_clock_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_)
    );

    app_top dut_i (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .spi_rst_          (spi_rst_),
        .data_in           (data_in),
        .data_out          (data_out),
        .data_oe           (data_oe),
        .led               (led),
        .dat_in_rst        (dat_in_rst),
        .dat_in_trigger    (dat_in_trigger),
        .dat_in_data       (dat_in_data)
    );

    // ==============================
    // Helpers
    // ==============================
    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            fail_count++;
            $display("CHECK FAILED at %0t: %s (got 0x%0h, expected 0x%0h)",
                     $time, what, actual, expected);
        end
    endtask

    task automatic tick();
        @(posedge sd_datInWrite_clk);
        #10;   // Drive and sample point
    endtask

    task automatic print_summary();
        $display("Summary: %0d checks, %0d check failures, %0d missing responses",
                 check_count, fail_count, missing_count);
    endtask

    function automatic app_pkg::msg_t make_msg(input app_pkg::msg_type_t t,
                                               input app_pkg::msg_arg_t a);
        app_pkg::msg_t m;
        m.msg_type = t;
        m.msg_arg  = a;
        return m;
    endfunction

    // Echo answer: argument in 63:8, zeros below
    function automatic app_pkg::resp_word_t echo_resp(input app_pkg::msg_arg_t a);
        app_pkg::resp_word_t r;
        r       = '0;
        r[63:8] = a;
        return r;
    endfunction

    // Status answer: mode 63:60, done 59, count 58:53
    function automatic app_pkg::resp_word_t status_resp(input logic [3:0] mode,
                                                        input logic done,
                                                        input logic [5:0] count);
        app_pkg::resp_word_t r;
        r        = '0;
        r[63:60] = mode;
        r[59]    = done;
        r[58:53] = count;
        return r;
    endfunction

    function automatic step_t msg_step(input app_pkg::msg_t m, input logic resp_exp,
                                       input app_pkg::resp_word_t r, input app_pkg::led_t l);
        step_t s;
        s          = '0;
        s.msg      = m;
        s.resp_exp = resp_exp;
        s.resp     = r;
        s.led      = l;
        return s;
    endfunction

    function automatic step_t burst_step(input int count, input logic rst_first,
                                         input logic rand_data, input logic gaps,
                                         input app_pkg::access_mode_t mode);
        step_t s;
        s           = '0;
        s.is_burst  = 1'b1;
        s.count     = app_pkg::word_count_t'(count);
        s.rst_first = rst_first;
        s.rand_data = rand_data;
        s.gaps      = gaps;
        s.mode      = mode;
        return s;
    endfunction

    // Rough upper bound of cycles taken by one step
    function automatic int step_len(input step_t s);
        if (s.is_burst) begin
            return 5 + 4 * s.count;
        end
        return `APP_MSG_LEN + `APP_RESP_LEN + 10;
    endfunction

    // ==============================
    // Stimulus table
    // ==============================
    task automatic build_table();
        logic [63:0] rnd;
        int          k;
        steps.push_back(msg_step(make_msg(`APP_TYPE_STATUS, '0), 1'b1,
                                 status_resp(4'h0, 1'b0, 6'd0), 4'h0));
        for (k = 0; k < 3; k++) begin
            rnd = {$urandom, $urandom};
            steps.push_back(msg_step(make_msg(`APP_TYPE_ECHO, rnd[55:0]), 1'b1,
                                     echo_resp(rnd[55:0]), 4'h0));
        end
        rnd = {$urandom, $urandom};   // Upper arg bits must not reach the LEDs
        steps.push_back(msg_step(make_msg(`APP_TYPE_LED_SET, {rnd[55:4], 4'h5}),
                                 1'b0, '0, 4'h5));
        rnd = {$urandom, $urandom};
        steps.push_back(msg_step(make_msg(`APP_TYPE_LED_SET, {rnd[55:4], 4'hA}),
                                 1'b0, '0, 4'hA));
        steps.push_back(msg_step(make_msg(`APP_TYPE_NOP, 56'h3), 1'b0, '0, 4'hA));
        // Partial block
        steps.push_back(burst_step(12, 1'b1, 1'b1, 1'b0, 4'hA));
        steps.push_back(msg_step(make_msg(`APP_TYPE_STATUS, '0), 1'b1,
                                 status_resp(4'hA, 1'b0, 6'd12), 4'hA));
        // Full block with gaps, then extra words that must be ignored
        steps.push_back(burst_step(32, 1'b1, 1'b1, 1'b1, 4'h3));
        steps.push_back(burst_step(3, 1'b0, 1'b1, 1'b0, 4'h0));
        steps.push_back(msg_step(make_msg(`APP_TYPE_STATUS, '0), 1'b1,
                                 status_resp(4'h3, 1'b1, 6'd32), 4'hA));
        steps.push_back(burst_step(0, 1'b1, 1'b0, 1'b0, 4'h0));
        steps.push_back(msg_step(make_msg(`APP_TYPE_STATUS, '0), 1'b1,
                                 status_resp(4'h3, 1'b0, 6'd0), 4'hA));
        // Unknown type with response flag
        steps.push_back(msg_step(make_msg(8'hC5, 56'hF), 1'b1, '0, 4'hA));
        rnd = {$urandom, $urandom};
        steps.push_back(msg_step(make_msg(`APP_TYPE_ECHO, rnd[55:0]), 1'b1,
                                 echo_resp(rnd[55:0]), 4'hA));
    endtask

    // ==============================
    // Serial host
    // ==============================
    task automatic run_message(input step_t st);
        logic [63:0] bits;
        logic [63:0] got;
        logic [63:0] oe_bits;
        int          low_run;
        bits = st.msg;
        for (int i = `APP_MSG_LEN - 1; i >= 0; i--) begin
            data_in = bits[i];
            tick();
        end
        data_in = 1'b0;   // Now just after S+63
        tick();
        check_value(dut_i.msg_valid, 1'b1, "msg_valid at S+64");
        check_value(dut_i.msg, st.msg, "decoded message");
        check_value(led, prev_led, "led before execution");
        tick();
        check_value(led, st.led, "led at S+65");
        check_value(data_oe, 1'b0, "data_oe at S+65");
        prev_led = st.led;
        if (st.resp_exp) begin
            resp_window = 1'b1;
            tick();
            if (!data_oe) begin
                missing_count++;
                $display("At %0t no response came for message 0x%h, data_oe still low at S+66",
                         $time, bits);
            end else begin
                for (int j = `APP_RESP_LEN - 1; j >= 0; j--) begin
                    got[j]     = data_out;
                    oe_bits[j] = data_oe;
                    tick();
                end
                check_value(oe_bits, {64{1'b1}}, "data_oe during response");
                check_value(data_oe, 1'b0, "data_oe after last bit");
                check_value(got, st.resp, "response word");
            end
        end
        // Host rule, line idle until data_oe stays low for 4 cycles
        low_run = 0;
        while (low_run < 4) begin
            low_run = data_oe ? 0 : low_run + 1;
            tick();
        end
        resp_window = 1'b0;
    endtask

    // ==============================
    // Data-in bursts
    // ==============================
    task automatic run_burst(input step_t st);
        app_pkg::dat_word_t  word;
        app_pkg::sd_status_t stat;
        if (st.rst_first) begin
            dat_in_rst = 1'b1;
            tick();
            dat_in_rst = 1'b0;
            blk_idx    = 0;
            blk_full   = 1'b0;
        end
        for (int n = 0; n < st.count; n++) begin
            if (st.gaps) begin
                repeat ($urandom_range(3, 1)) tick();
            end
            word = st.rand_data ? app_pkg::dat_word_t'($urandom) : '0;
            if (!blk_full && blk_idx == `APP_CMD6_WORD_IDX) begin
                word[`APP_CMD6_MODE_LSB +: 4] = st.mode;
            end
            dat_in_trigger = 1'b1;
            dat_in_data    = word;
            tick();
            dat_in_trigger = 1'b0;
            dat_in_data    = '0;
            if (!blk_full) begin
                blk_idx++;
                blk_full = (blk_idx == `APP_BLOCK_WORDS);
            end
            stat = dut_i.status;   // Updated one cycle after the edge
            check_value(stat.word_count, blk_idx, "word_count after word");
            check_value(stat.block_done, blk_full, "block_done after word");
        end
        tick();
        tick();
    endtask

    // data_oe may only be high inside a response window
    always @(negedge sd_datInWrite_clk) begin
        if (spi_rst_ && !resp_window) begin
            check_value(data_oe, 1'b0, "data_oe outside a response");
        end
    end

    // ==============================
    // Watchdog
    // ==============================
    always @(posedge sd_datInWrite_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            print_summary();
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        seed_val       = $urandom(46);
        data_in        = 1'b0;
        dat_in_rst     = 1'b0;
        dat_in_trigger = 1'b0;
        dat_in_data    = '0;
        check_count    = 0;
        fail_count     = 0;
        missing_count  = 0;
        cycle_count    = 0;
        resp_window    = 1'b0;
        prev_led       = '0;
        blk_idx        = 0;
        blk_full       = 1'b0;
        build_table();
        cycle_limit = 200;
        foreach (steps[i]) begin
            cycle_limit += 2 * step_len(steps[i]);
        end
        wait (spi_rst_ === 1'b1);
        tick();
        check_value(led, 4'h0, "led after reset");
        check_value(dut_i.status, '0, "status after reset");
        foreach (steps[i]) begin
            if (steps[i].is_burst) begin
                run_burst(steps[i]);
            end else begin
                run_message(steps[i]);
            end
        end
        repeat (4) tick();
        print_summary();
        if (fail_count == 0 && missing_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/app_pkg.sv
hw/msg_decoder.sv
hw/cmd_executor.sv
hw/resp_shifter.sv
hw/cmd6_capture.sv
hw/app_top.sv
verification/tb_clock.sv
verification/app_tb.sv
